// ==== adc_if_defs.svh ====
// sizing of the capture datapath
// conversion timing and AXI4-Lite register map offsets

`ifndef ADC_IF_DEFS_SVH
`define ADC_IF_DEFS_SVH

// sample width and lane setup
`define ADC_RESOLUTION     18
`define ADC_TWO_LANES      1
`define ADC_FRAME_BITS     (`ADC_RESOLUTION / (`ADC_TWO_LANES + 1))

// clocks from cnv to the first gated bit clock
`define ADC_TCONV_CYCLES   4
`define ADC_MIN_PERIOD     (1 + `ADC_TCONV_CYCLES + `ADC_FRAME_BITS + 2)

// register byte offsets
`define ADC_REG_CTRL       16'h0000
`define ADC_REG_PERIOD     16'h0004
`define ADC_REG_STATUS     16'h0008
`define ADC_REG_SAMPLE     16'h000C
`define ADC_REG_COUNT      16'h0010
`define ADC_REG_VERSION    16'h0014
`define ADC_VERSION        32'h0001_0200

`endif

// ==== adc_if_pkg.sv ====
// shared types of the capture subsystem
// sample, period, count and register bus words plus the timer states

`include "adc_if_defs.svh"

package adc_if_pkg;

  // one converted code
  typedef logic [`ADC_RESOLUTION-1:0] adc_sample_t;

  // conversion period in s_axi_aclk cycles
  typedef logic [15:0] adc_period_t;

  // running number of captured samples
  typedef logic [31:0] adc_count_t;

  // register byte address and register word
  typedef logic [15:0] axi_addr_t;
  typedef logic [31:0] axi_data_t;

  // conversion timer FSM
  typedef enum logic [2:0] {
    IDLE    = 3'd0,
    CNV     = 3'd1,
    CONVERT = 3'd2,
    GATE    = 3'd3,
    HOLD    = 3'd4
  } cnv_state_t;

endpackage

// ==== adc_ctrl_if.sv ====
// control and status bundle between register block and datapath

`timescale 1ns/1ps

interface adc_ctrl_if;

  // software controls
  logic                    enable;
  adc_if_pkg::adc_period_t period;

  // datapath status
  logic                    frame_active;
  adc_if_pkg::adc_sample_t sample;
  logic                    sample_valid;

  // register block owns the controls and watches everything else
  modport regmap (
    output enable, period,
    input  sample, sample_valid, frame_active
  );

  // timer runs from the controls and flags a frame in flight
  modport timer (
    input  enable, period,
    output frame_active
  );

  // deserializer hands out finished samples
  modport deser (output sample, sample_valid);

endinterface

// ==== adc_cnv_timer.sv ====
// conversion timer
// cnv pulse, conversion wait and gated bit clock window per period

`timescale 1ns/1ps

`include "adc_if_defs.svh"

module adc_cnv_timer (
  input  logic      s_axi_aclk,
  input  logic      rst,
  adc_ctrl_if.timer ctrl,
  output logic      cnv,
  output logic      clk_gate
);

  // down-counter loads, convert state is entered one cycle after cnv
  localparam logic [7:0] conv_load  = 8'(`ADC_TCONV_CYCLES - 2);
  localparam logic [7:0] frame_load = 8'(`ADC_FRAME_BITS - 1);

  adc_if_pkg::cnv_state_t  state;
  adc_if_pkg::cnv_state_t  state_next;
  logic [7:0]              step_cnt;
  adc_if_pkg::adc_period_t period_cnt;

  // ****************************
  // next state
  // ****************************
  always_comb begin
    state_next = state;
    case (state)
      adc_if_pkg::IDLE: begin
        if (ctrl.enable) begin
          state_next = adc_if_pkg::CNV;
        end
      end
      adc_if_pkg::CNV: state_next = adc_if_pkg::CONVERT;
      adc_if_pkg::CONVERT: begin
        if (step_cnt == 8'd0) begin
          state_next = adc_if_pkg::GATE;
        end
      end
      adc_if_pkg::GATE: begin
        if (step_cnt == 8'd0) begin
          state_next = adc_if_pkg::HOLD;
        end
      end
      adc_if_pkg::HOLD: begin
        // end of period, a cleared enable stops here
        if (period_cnt == '0) begin
          state_next = ctrl.enable ? adc_if_pkg::CNV : adc_if_pkg::IDLE;
        end
      end
      default: state_next = adc_if_pkg::IDLE;
    endcase
  end

  // ****************************
  // state and counters
  // ****************************
  always_ff @(posedge s_axi_aclk) begin
    if (rst) begin
      state      <= adc_if_pkg::IDLE;
      step_cnt   <= '0;
      period_cnt <= '0;
    end else begin
      state <= state_next;
      // period counter reads period-1 in the cnv cycle and hits zero in the last one
      if (state_next == adc_if_pkg::CNV) begin
        period_cnt <= ctrl.period - 16'd1;
      end else if (period_cnt != '0) begin
        period_cnt <= period_cnt - 16'd1;
      end
      // one counter shared by the conversion wait and the gate window
      if (state == adc_if_pkg::CNV) begin
        step_cnt <= conv_load;
      end else if (state == adc_if_pkg::CONVERT && step_cnt == 8'd0) begin
        step_cnt <= frame_load;
      end else if (step_cnt != 8'd0) begin
        step_cnt <= step_cnt - 8'd1;
      end
    end
  end

  // moore outputs straight from the state register
  assign cnv               = (state == adc_if_pkg::CNV);
  assign clk_gate          = (state == adc_if_pkg::GATE);
  assign ctrl.frame_active = (state == adc_if_pkg::CNV) || (state == adc_if_pkg::CONVERT) ||
                             (state == adc_if_pkg::GATE);

  // gate opens only after the full conversion time and never during cnv
  a_cnv_gate_apart: assert property (@(posedge s_axi_aclk) disable iff (rst)
    !(cnv && clk_gate));
  a_gate_after_tconv: assert property (@(posedge s_axi_aclk) disable iff (rst)
    $rose(clk_gate) |-> $past(cnv, `ADC_TCONV_CYCLES));

endmodule

// ==== adc_lane_deser.sv ====
// lane deserializer
// shifts da/db during the gated frame and emits one sample per frame

`timescale 1ns/1ps

`include "adc_if_defs.svh"

module adc_lane_deser (
  input  logic      s_axi_aclk,
  input  logic      rst,
  input  logic      clk_gate,
  input  logic      da,
  input  logic      db,
  adc_ctrl_if.deser ctrl
);

  localparam int         res      = `ADC_RESOLUTION;
  localparam logic [4:0] last_bit = 5'(`ADC_FRAME_BITS - 1);

  logic                    gate_q;
  logic [4:0]              bit_cnt;
  adc_if_pkg::adc_sample_t shift_q;
  adc_if_pkg::adc_sample_t shift_next;
  adc_if_pkg::adc_sample_t sample_q;
  logic                    valid_q;

  // ****************************
  // shift path
  // ****************************
  // msb first, da holds the odd bit of each pair
  always_comb begin
    if (`ADC_TWO_LANES != 0) begin
      shift_next = {shift_q[res-3:0], da, db};
    end else begin
      shift_next = {shift_q[res-2:0], da};
    end
  end

  // bits arrive one edge behind the gate so sample on the delayed copy
  always_ff @(posedge s_axi_aclk) begin
    if (gate_q) begin
      shift_q <= shift_next;
    end
    // frame end grabs the last pair directly
    if (gate_q && bit_cnt == last_bit) begin
      sample_q <= shift_next;
    end
  end

  // ****************************
  // frame control
  // ****************************
  always_ff @(posedge s_axi_aclk) begin
    if (rst) begin
      gate_q  <= 1'b0;
      bit_cnt <= '0;
      valid_q <= 1'b0;
    end else begin
      gate_q  <= clk_gate;
      valid_q <= gate_q && (bit_cnt == last_bit);
      // restart count whenever the gate is idle
      if (!gate_q || bit_cnt == last_bit) begin
        bit_cnt <= '0;
      end else begin
        bit_cnt <= bit_cnt + 5'd1;
      end
    end
  end

  assign ctrl.sample       = sample_q;
  assign ctrl.sample_valid = valid_q;

  // one pulse per frame
  a_valid_single: assert property (@(posedge s_axi_aclk) disable iff (rst)
    ctrl.sample_valid |=> !ctrl.sample_valid);

endmodule

// ==== axi_adc_regmap.sv ====
// AXI4-Lite register block
// control, clamped period, status with sticky overflow, last sample, count, version

`timescale 1ns/1ps

`include "adc_if_defs.svh"

module axi_adc_regmap (
  input  logic                  s_axi_aclk,
  input  logic                  rst,
  input  logic                  s_axi_awvalid,
  input  adc_if_pkg::axi_addr_t s_axi_awaddr,
  output logic                  s_axi_awready,
  input  logic                  s_axi_wvalid,
  input  adc_if_pkg::axi_data_t s_axi_wdata,
  output logic                  s_axi_wready,
  output logic                  s_axi_bvalid,
  output logic [1:0]            s_axi_bresp,
  input  logic                  s_axi_bready,
  input  logic                  s_axi_arvalid,
  input  adc_if_pkg::axi_addr_t s_axi_araddr,
  output logic                  s_axi_arready,
  output logic                  s_axi_rvalid,
  output logic [1:0]            s_axi_rresp,
  output adc_if_pkg::axi_data_t s_axi_rdata,
  input  logic                  s_axi_rready,
  input  logic                  adc_dovf,
  adc_ctrl_if.regmap            ctrl
);

  localparam adc_if_pkg::adc_period_t min_period = 16'(`ADC_MIN_PERIOD);

  logic                    wr_start;
  logic                    wr_en;
  logic                    rd_start;
  logic                    rd_en;
  logic                    enable_q;
  adc_if_pkg::adc_period_t period_q;
  adc_if_pkg::adc_period_t period_wr;
  logic                    ovf_q;
  adc_if_pkg::adc_sample_t last_sample;
  adc_if_pkg::adc_count_t  sample_cnt;
  adc_if_pkg::axi_data_t   rd_word;

  // ****************************
  // write channel
  // ****************************
  // accept only when address and data are both there and no response is pending
  assign wr_start = s_axi_awvalid && s_axi_wvalid && !s_axi_awready && !s_axi_bvalid;
  assign wr_en    = s_axi_awready && s_axi_awvalid && s_axi_wvalid;

  always_ff @(posedge s_axi_aclk) begin
    if (rst) begin
      s_axi_awready <= 1'b0;
      s_axi_wready  <= 1'b0;
      s_axi_bvalid  <= 1'b0;
    end else begin
      s_axi_awready <= wr_start;
      s_axi_wready  <= wr_start;
      if (wr_en) begin
        s_axi_bvalid <= 1'b1;
      end else if (s_axi_bready) begin
        s_axi_bvalid <= 1'b0;
      end
    end
  end

  // short periods are raised to the minimum
  assign period_wr = (s_axi_wdata[15:0] < min_period) ? min_period : s_axi_wdata[15:0];

  // ****************************
  // registers
  // ****************************
  always_ff @(posedge s_axi_aclk) begin
    if (rst) begin
      enable_q    <= 1'b0;
      period_q    <= min_period;
      ovf_q       <= 1'b0;
      last_sample <= '0;
      sample_cnt  <= '0;
    end else begin
      if (wr_en && s_axi_awaddr == `ADC_REG_CTRL) begin
        enable_q <= s_axi_wdata[0];
      end
      if (wr_en && s_axi_awaddr == `ADC_REG_PERIOD) begin
        period_q <= period_wr;
      end
      // overflow set wins over a clear in the same cycle
      if (adc_dovf) begin
        ovf_q <= 1'b1;
      end else if (wr_en && s_axi_awaddr == `ADC_REG_STATUS && s_axi_wdata[0]) begin
        ovf_q <= 1'b0;
      end
      if (ctrl.sample_valid) begin
        last_sample <= ctrl.sample;
        sample_cnt  <= sample_cnt + 32'd1;
      end
    end
  end

  assign ctrl.enable = enable_q;
  assign ctrl.period = period_q;

  // ****************************
  // read channel
  // ****************************
  assign rd_start = s_axi_arvalid && !s_axi_arready && !s_axi_rvalid;
  assign rd_en    = s_axi_arready && s_axi_arvalid;

  always_comb begin
    case (s_axi_araddr)
      `ADC_REG_CTRL:    rd_word = {31'd0, enable_q};
      `ADC_REG_PERIOD:  rd_word = {16'd0, period_q};
      `ADC_REG_STATUS:  rd_word = {30'd0, ctrl.frame_active, ovf_q};
      `ADC_REG_SAMPLE:  rd_word = adc_if_pkg::axi_data_t'(last_sample);
      `ADC_REG_COUNT:   rd_word = sample_cnt;
      `ADC_REG_VERSION: rd_word = `ADC_VERSION;
      default:          rd_word = '0;
    endcase
  end

  always_ff @(posedge s_axi_aclk) begin
    if (rst) begin
      s_axi_arready <= 1'b0;
      s_axi_rvalid  <= 1'b0;
    end else begin
      s_axi_arready <= rd_start;
      if (rd_en) begin
        s_axi_rvalid <= 1'b1;
      end else if (s_axi_rready) begin
        s_axi_rvalid <= 1'b0;
      end
    end
  end

  // read word is payload and latched at the address handshake
  always_ff @(posedge s_axi_aclk) begin
    if (rd_en) begin
      s_axi_rdata <= rd_word;
    end
  end

  // always OKAY
  assign s_axi_bresp = 2'b00;
  assign s_axi_rresp = 2'b00;

  // a write response is never withdrawn before the master takes it
  a_bvalid_hold: assert property (@(posedge s_axi_aclk) disable iff (rst)
    s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid);

endmodule

// ==== adc_if_top.sv ====
// capture subsystem top level
// conversion timer, lane deserializer and AXI4-Lite registers on one clock

`timescale 1ns/1ps

module adc_if_top (
  input  logic                    s_axi_aclk,
  input  logic                    rst,
  input  logic                    s_axi_awvalid,
  input  adc_if_pkg::axi_addr_t   s_axi_awaddr,
  output logic                    s_axi_awready,
  input  logic                    s_axi_wvalid,
  input  adc_if_pkg::axi_data_t   s_axi_wdata,
  output logic                    s_axi_wready,
  output logic                    s_axi_bvalid,
  output logic [1:0]              s_axi_bresp,
  input  logic                    s_axi_bready,
  input  logic                    s_axi_arvalid,
  input  adc_if_pkg::axi_addr_t   s_axi_araddr,
  output logic                    s_axi_arready,
  output logic                    s_axi_rvalid,
  output logic [1:0]              s_axi_rresp,
  output adc_if_pkg::axi_data_t   s_axi_rdata,
  input  logic                    s_axi_rready,
  input  logic                    adc_dovf,
  input  logic                    da,
  input  logic                    db,
  output logic                    cnv,
  output logic                    clk_gate,
  output logic                    adc_valid,
  output adc_if_pkg::adc_sample_t adc_data
);

  // control and status between the three blocks
  adc_ctrl_if u_ctrl ();

  adc_cnv_timer u_timer (
    .s_axi_aclk (s_axi_aclk),
    .rst        (rst),
    .ctrl       (u_ctrl.timer),
    .cnv        (cnv),
    .clk_gate   (clk_gate)
  );

  adc_lane_deser u_deser (
    .s_axi_aclk (s_axi_aclk),
    .rst        (rst),
    .clk_gate   (clk_gate),
    .da         (da),
    .db         (db),
    .ctrl       (u_ctrl.deser)
  );

  axi_adc_regmap u_regmap (
    .s_axi_aclk          (s_axi_aclk),
    .rst                 (rst),
    .s_axi_awvalid       (s_axi_awvalid),
    .s_axi_awaddr        (s_axi_awaddr),
    .s_axi_awready       (s_axi_awready),
    .s_axi_wvalid        (s_axi_wvalid),
    .s_axi_wdata         (s_axi_wdata),
    .s_axi_wready        (s_axi_wready),
    .s_axi_bvalid        (s_axi_bvalid),
    .s_axi_bresp         (s_axi_bresp),
    .s_axi_bready        (s_axi_bready),
    .s_axi_arvalid       (s_axi_arvalid),
    .s_axi_araddr        (s_axi_araddr),
    .s_axi_arready       (s_axi_arready),
    .s_axi_rvalid        (s_axi_rvalid),
    .s_axi_rresp         (s_axi_rresp),
    .s_axi_rdata         (s_axi_rdata),
    .s_axi_rready        (s_axi_rready),
    .adc_dovf            (adc_dovf),
    .ctrl                (u_ctrl.regmap)
  );

  // sample stream to the DMA
  assign adc_valid = u_ctrl.sample_valid;
  assign adc_data  = u_ctrl.sample;

endmodule

// ==== adc_chip_model.sv ====
// converter model for the testbench
// draws a code at each cnv and shifts it out on da/db through the gate window

`timescale 1ns/1ps

`include "adc_if_defs.svh"

module adc_chip_model (
  input  logic                  s_axi_aclk,
  input  logic                  cnv,
  input  logic                  clk_gate,
  output logic                  da,
  output logic                  db,
  output adc_if_pkg::axi_data_t code,
  output logic                  code_stb
);

  localparam int res = `ADC_RESOLUTION;

  integer seed;
  int     bit_idx;
  logic   cnv_s;
  logic   gate_s;

  initial begin
    seed     = 32'h6d33;
    da       = 1'b0;
    db       = 1'b0;
    code     = '0;
    code_stb = 1'b0;
    bit_idx  = 0;
    forever begin
      // strobes seen mid cycle are the values at the coming rising edge
      @(negedge s_axi_aclk);
      cnv_s  = cnv;
      gate_s = clk_gate;
      @(posedge s_axi_aclk);
      #1;
      code_stb = 1'b0;
      // new raw draw per conversion, only the low bits go out
      if (cnv_s) begin
        code     = $random(seed);
        code_stb = 1'b1;
        bit_idx  = 0;
      end
      if (gate_s) begin
        // msb first, da takes the upper bit of each pair
        if (`ADC_TWO_LANES != 0) begin
          da = code[res-1-2*bit_idx];
          db = code[res-2-2*bit_idx];
        end else begin
          da = code[res-1-bit_idx];
          db = 1'b0;
        end
        bit_idx = bit_idx + 1;
      end
    end
  end

endmodule

// ==== tb_adc_if_top.sv ====
// testbench for the capture subsystem
// AXI4-Lite tasks, converter model, sample checker, timing monitor and watchdog

`timescale 1ns/1ps

`include "adc_if_defs.svh"

module tb_adc_if_top;

  localparam int          tconv       = `ADC_TCONV_CYCLES;
  localparam int          frame_bits  = `ADC_FRAME_BITS;
  localparam logic [31:0] min_period  = 32'(`ADC_MIN_PERIOD);
  localparam int          slow_period = 40;
  localparam int          n_fast      = 6;
  localparam int          n_min       = 5;
  localparam int          axi_limit   = 20;
  // all frames of all scenarios plus room for register traffic
  localparam int          wd_cycles   = (n_fast + 3) * slow_period +
                                        (n_min + 23) * `ADC_MIN_PERIOD + 3000;

  logic                    s_axi_aclk;
  logic                    rst;
  logic                    s_axi_awvalid;
  adc_if_pkg::axi_addr_t   s_axi_awaddr;
  logic                    s_axi_awready;
  logic                    s_axi_wvalid;
  adc_if_pkg::axi_data_t   s_axi_wdata;
  logic                    s_axi_wready;
  logic                    s_axi_bvalid;
  logic [1:0]              s_axi_bresp;
  logic                    s_axi_bready;
  logic                    s_axi_arvalid;
  adc_if_pkg::axi_addr_t   s_axi_araddr;
  logic                    s_axi_arready;
  logic                    s_axi_rvalid;
  logic [1:0]              s_axi_rresp;
  adc_if_pkg::axi_data_t   s_axi_rdata;
  logic                    s_axi_rready;
  logic                    adc_dovf;
  logic                    da;
  logic                    db;
  logic                    cnv;
  logic                    clk_gate;
  logic                    adc_valid;
  adc_if_pkg::adc_sample_t adc_data;
  adc_if_pkg::axi_data_t   model_code;
  logic                    model_stb;

  // scoreboard and monitor state
  logic [31:0] code_q[$];
  logic [31:0] exp_word;
  logic [31:0] last_exp;
  int          errors;
  int          checks;
  int          samples_seen;
  int          codes_drawn;
  int          exp_gap;
  int          cyc;
  int          last_cnv;
  int          last_gate;
  int          cnv_total;
  int          gate_len;
  logic        gate_prev;

  adc_if_top u_dut (
    .s_axi_aclk    (s_axi_aclk),
    .rst           (rst),
    .s_axi_awvalid (s_axi_awvalid),
    .s_axi_awaddr  (s_axi_awaddr),
    .s_axi_awready (s_axi_awready),
    .s_axi_wvalid  (s_axi_wvalid),
    .s_axi_wdata   (s_axi_wdata),
    .s_axi_wready  (s_axi_wready),
    .s_axi_bvalid  (s_axi_bvalid),
    .s_axi_bresp   (s_axi_bresp),
    .s_axi_bready  (s_axi_bready),
    .s_axi_arvalid (s_axi_arvalid),
    .s_axi_araddr  (s_axi_araddr),
    .s_axi_arready (s_axi_arready),
    .s_axi_rvalid  (s_axi_rvalid),
    .s_axi_rresp   (s_axi_rresp),
    .s_axi_rdata   (s_axi_rdata),
    .s_axi_rready  (s_axi_rready),
    .adc_dovf      (adc_dovf),
    .da            (da),
    .db            (db),
    .cnv           (cnv),
    .clk_gate      (clk_gate),
    .adc_valid     (adc_valid),
    .adc_data      (adc_data)
  );

  adc_chip_model u_model (
    .s_axi_aclk (s_axi_aclk),
    .cnv        (cnv),
    .clk_gate   (clk_gate),
    .da         (da),
    .db         (db),
    .code       (model_code),
    .code_stb   (model_stb)
  );

  initial begin
    s_axi_aclk = 1'b0;
    forever #5 s_axi_aclk = ~s_axi_aclk;
  end

  // ****************************
  // reference model and checks
  // ****************************
  // only the low resolution bits of a draw reach the lanes
  function automatic logic [31:0] expected_sample(input logic [31:0] raw);
    return raw & ((32'd1 << `ADC_RESOLUTION) - 32'd1);
  endfunction

  // short periods read back as the minimum
  function automatic logic [31:0] expected_period(input logic [31:0] wr);
    if ({16'd0, wr[15:0]} < min_period) begin
      return min_period;
    end
    return {16'd0, wr[15:0]};
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s got 0x%08h expected 0x%08h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic note_error(input string msg);
    errors++;
    $display("error at %0t: %s", $time, msg);
  endtask

  // ****************************
  // AXI4-Lite master
  // ****************************
  task automatic axi_write(input logic [15:0] addr, input logic [31:0] data);
    int waited;
    @(posedge s_axi_aclk);
    #1;
    s_axi_awvalid = 1'b1;
    s_axi_awaddr  = addr;
    s_axi_wvalid  = 1'b1;
    s_axi_wdata   = data;
    waited = 0;
    @(negedge s_axi_aclk);
    while (!(s_axi_awready && s_axi_wready) && waited < axi_limit) begin
      @(negedge s_axi_aclk);
      waited++;
    end
    if (!(s_axi_awready && s_axi_wready)) begin
      note_error("write address and data were never accepted");
    end
    @(posedge s_axi_aclk);
    #1;
    s_axi_awvalid = 1'b0;
    s_axi_wvalid  = 1'b0;
    waited = 0;
    @(negedge s_axi_aclk);
    while (!s_axi_bvalid && waited < axi_limit) begin
      @(negedge s_axi_aclk);
      waited++;
    end
    if (!s_axi_bvalid) begin
      note_error("no write response arrived");
    end else begin
      check_value("s_axi_bresp", 32'(s_axi_bresp), 32'd0);
      // bready held off one cycle, the response has to stay up
      @(posedge s_axi_aclk);
      #1;
      s_axi_bready = 1'b1;
      @(negedge s_axi_aclk);
      check_value("s_axi_bvalid", 32'(s_axi_bvalid), 32'd1);
    end
    @(posedge s_axi_aclk);
    #1;
    s_axi_bready = 1'b0;
  endtask

  task automatic axi_read(input logic [15:0] addr, output logic [31:0] data);
    int waited;
    @(posedge s_axi_aclk);
    #1;
    s_axi_arvalid = 1'b1;
    s_axi_araddr  = addr;
    waited = 0;
    @(negedge s_axi_aclk);
    while (!s_axi_arready && waited < axi_limit) begin
      @(negedge s_axi_aclk);
      waited++;
    end
    if (!s_axi_arready) begin
      note_error("read address was never accepted");
    end
    @(posedge s_axi_aclk);
    #1;
    s_axi_arvalid = 1'b0;
    waited = 0;
    @(negedge s_axi_aclk);
    while (!s_axi_rvalid && waited < axi_limit) begin
      @(negedge s_axi_aclk);
      waited++;
    end
    data = s_axi_rdata;
    if (!s_axi_rvalid) begin
      note_error("no read data arrived");
    end else begin
      check_value("s_axi_rresp", 32'(s_axi_rresp), 32'd0);
      // rready held off one cycle, read data has to stay up
      @(posedge s_axi_aclk);
      #1;
      s_axi_rready = 1'b1;
      @(negedge s_axi_aclk);
      check_value("s_axi_rvalid", 32'(s_axi_rvalid), 32'd1);
    end
    @(posedge s_axi_aclk);
    #1;
    s_axi_rready = 1'b0;
  endtask

  task automatic read_expect(input string name, input logic [15:0] addr,
                             input logic [31:0] exp);
    logic [31:0] rd;
    axi_read(addr, rd);
    check_value(name, rd, exp);
  endtask

  // returns just after the edge that ends a cnv cycle
  task automatic wait_cnv();
    int waited;
    waited = 0;
    @(negedge s_axi_aclk);
    while (!cnv && waited < 4 * slow_period) begin
      @(negedge s_axi_aclk);
      waited++;
    end
    if (!cnv) begin
      note_error("cnv never pulsed while capture was enabled");
    end
    @(posedge s_axi_aclk);
    #1;
  endtask

  task automatic wait_samples(input int n, input int max_cycles);
    int target;
    int waited;
    target = samples_seen + n;
    waited = 0;
    while (samples_seen < target && waited < max_cycles) begin
      @(posedge s_axi_aclk);
      waited++;
    end
    if (samples_seen < target) begin
      note_error("too few samples arrived before the wait ran out");
    end
  endtask

  // ****************************
  // monitors
  // ****************************
  // codes enter the queue as drawn and leave with each adc_valid
  always @(negedge s_axi_aclk) begin
    if (!rst) begin
      if (model_stb) begin
        code_q.push_back(model_code);
        codes_drawn++;
      end
      if (adc_valid) begin
        if (code_q.size() == 0) begin
          note_error("adc_valid pulsed with no code drawn by the converter model");
        end else begin
          exp_word = expected_sample(code_q.pop_front());
          check_value("adc_data", 32'(adc_data), exp_word);
          last_exp = exp_word;
          samples_seen++;
        end
      end
    end
  end

  // cnv spacing, conversion time, gate width and sample latency in cycles
  always @(negedge s_axi_aclk) begin
    if (rst) begin
      cyc       = 0;
      last_cnv  = 0;
      last_gate = 0;
      cnv_total = 0;
      gate_len  = 0;
      gate_prev = 1'b0;
    end else begin
      cyc = cyc + 1;
      if (cnv) begin
        if (exp_gap != 0) begin
          check_value("cnv period", 32'(cyc - last_cnv), 32'(exp_gap));
        end
        last_cnv  = cyc;
        cnv_total = cnv_total + 1;
      end
      if (clk_gate && !gate_prev) begin
        check_value("cnv to clk_gate", 32'(cyc - last_cnv), 32'(tconv));
      end
      if (clk_gate) begin
        gate_len  = gate_len + 1;
        last_gate = cyc;
      end else if (gate_prev) begin
        check_value("clk_gate width", 32'(gate_len), 32'(frame_bits));
        gate_len = 0;
      end
      // sample leaves two cycles after the last gated bit clock
      if (adc_valid) begin
        check_value("adc_valid delay", 32'(cyc - last_gate), 32'd2);
      end
      gate_prev = clk_gate;
    end
  end

  initial begin
    repeat (wd_cycles) @(posedge s_axi_aclk);
    $display("watchdog expired after %0d cycles, the run did not finish", wd_cycles);
    $display("Test failed");
    $finish;
  end

  // ****************************
  // scenarios
  // ****************************
  initial begin
    logic [31:0] rd;
    int          polls;
    int          cnv_mark;
    rst           = 1'b1;
    s_axi_awvalid = 1'b0;
    s_axi_awaddr  = '0;
    s_axi_wvalid  = 1'b0;
    s_axi_wdata   = '0;
    s_axi_bready  = 1'b0;
    s_axi_arvalid = 1'b0;
    s_axi_araddr  = '0;
    s_axi_rready  = 1'b0;
    adc_dovf      = 1'b0;
    errors        = 0;
    checks        = 0;
    samples_seen  = 0;
    codes_drawn   = 0;
    exp_gap       = 0;
    last_exp      = '0;
    repeat (2) @(posedge s_axi_aclk);
    #1;
    rst = 1'b0;

    // quiet outputs and reset values
    repeat (8) begin
      @(negedge s_axi_aclk);
      check_value("cnv", 32'(cnv), 32'd0);
      check_value("clk_gate", 32'(clk_gate), 32'd0);
      check_value("adc_valid", 32'(adc_valid), 32'd0);
    end
    read_expect("version reg", `ADC_REG_VERSION, `ADC_VERSION);
    read_expect("ctrl reg", `ADC_REG_CTRL, 32'd0);
    read_expect("period reg", `ADC_REG_PERIOD, min_period);
    read_expect("count reg", `ADC_REG_COUNT, 32'd0);
    read_expect("status reg", `ADC_REG_STATUS, 32'd0);

    // capture at period 40, gap checks start from the first cnv
    axi_write(`ADC_REG_PERIOD, 32'(slow_period));
    read_expect("period reg", `ADC_REG_PERIOD, expected_period(32'(slow_period)));
    axi_write(`ADC_REG_CTRL, 32'd1);
    wait_cnv();
    exp_gap = slow_period;
    wait_samples(n_fast, (n_fast + 2) * slow_period);

    // too short a period is clamped, the next cnv loads it
    exp_gap = 0;
    axi_write(`ADC_REG_PERIOD, 32'd5);
    read_expect("period reg", `ADC_REG_PERIOD, expected_period(32'd5));
    wait_cnv();
    exp_gap = `ADC_MIN_PERIOD;
    wait_samples(n_min, (n_min + 4) * slow_period);

    // disable, let the last frame drain, then no further cnv
    exp_gap = 0;
    axi_write(`ADC_REG_CTRL, 32'd0);
    cnv_mark = cnv_total;
    polls = 0;
    rd = 32'd2;
    while (rd[1] && polls < 50) begin
      axi_read(`ADC_REG_STATUS, rd);
      polls++;
    end
    if (rd[1]) begin
      note_error("frame_active stayed high after capture was disabled");
    end
    polls = 0;
    while (code_q.size() != 0 && polls < 4 * slow_period) begin
      @(posedge s_axi_aclk);
      polls++;
    end
    repeat (3 * `ADC_MIN_PERIOD) @(posedge s_axi_aclk);
    check_value("cnv count after disable", 32'(cnv_total - cnv_mark), 32'd0);
    check_value("samples vs codes drawn", 32'(samples_seen), 32'(codes_drawn));
    read_expect("count reg", `ADC_REG_COUNT, 32'(codes_drawn));
    read_expect("sample reg", `ADC_REG_SAMPLE, last_exp);
    read_expect("status reg", `ADC_REG_STATUS, 32'd0);

    // sticky overflow and its write-1 clear
    @(posedge s_axi_aclk);
    #1;
    adc_dovf = 1'b1;
    @(posedge s_axi_aclk);
    #1;
    adc_dovf = 1'b0;
    read_expect("status reg", `ADC_REG_STATUS, 32'd1);
    repeat (10) @(posedge s_axi_aclk);
    read_expect("status reg", `ADC_REG_STATUS, 32'd1);
    axi_write(`ADC_REG_STATUS, 32'd1);
    read_expect("status reg", `ADC_REG_STATUS, 32'd0);

    repeat (5) @(posedge s_axi_aclk);
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
+incdir+.
adc_if_pkg.sv
adc_ctrl_if.sv
adc_cnv_timer.sv
adc_lane_deser.sv
axi_adc_regmap.sv
adc_if_top.sv
adc_chip_model.sv
tb_adc_if_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the capture subsystem testbench with Verilator and run it
# the run counts as failed on any tool error or a failing line in the log

cd "$(dirname "$0")" || exit 1

build_log=build.log
run_log=sim.log

verilator --binary --assert --top-module tb_adc_if_top -f sim.f -o sim_tb > "$build_log" 2>&1
if [ $? -ne 0 ]; then
  echo "verilator build failed, see $build_log"
  exit 1
fi

./obj_dir/sim_tb > "$run_log" 2>&1
status=$?
cat "$run_log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Test failed" "$run_log"; then
  exit 1
fi
if ! grep -q "Test passed" "$run_log"; then
  echo "simulation ended without a result line"
  exit 1
fi
exit 0
